// File: all.f
logic/gamePkg.sv
logic/rectFiller.sv
logic/shipStamper.sv
logic/gameRegs.sv
logic/frameSequencer.sv
logic/gameFrameTop.sv
testbench/gameFrame_sva.sv
testbench/gameFrameTb.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/VgameFrameTb: all.f $(SRCS)
	verilator --binary --assert --top-module gameFrameTb -f all.f

run: obj_dir/VgameFrameTb
	./obj_dir/VgameFrameTb > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/gameFrameTb.sv
`timescale 1ns/1ns

module gameFrameTb;

  import gamePkg::*;

  logic       clk;
  logic       rstN;
  cellT       shipX;
  cellT       shipY;
  cellT       targetX;
  pixelT      pixel;
  logic [7:0] hitCount;
  logic       frameDone;

  int    seed = 32'h58532807;
  int    frameLimit = 12000;          // cycles, the first frame is the longest
  int    mismatchCount;
  int    otherErrors;
  int    expHits;
  int    hitAfter;                    // hitCount one cycle after frameDone
  bit    aborted;
  int    colorCount [8];
  int    colorWrites [8][screenW][screenH];
  colorT screen [screenW][screenH];   // last color drawn at each position

  gameFrameTop u_gameFrameTop (
    .clk       (clk),
    .rstN      (rstN),
    .shipX     (shipX),
    .shipY     (shipY),
    .targetX   (targetX),
    .pixel     (pixel),
    .hitCount  (hitCount),
    .frameDone (frameDone)
  );

  bind gameFrameTop gameFrameSva u_gameFrameSva (
    .clk       (clk),
    .rstN      (rstN),
    .pixel     (pixel),
    .frameDone (frameDone)
  );

  always #20 clk = ~clk;

  task automatic checkValue(string testName, string what, int expected, int actual);
    if (expected != actual)
    begin
      mismatchCount++;
      $display("mismatch %s %s expected %0d actual %0d", testName, what, expected, actual);
    end
  endtask

  function automatic int clampTo(int value, int limit);
    return (value > limit) ? limit : value;
  endfunction

  // ship bitmap as drawn, row by row
  function automatic bit shipPixelSet(int row, int col);
    case (row)
      0:       return (col == 2) || (col == 3);
      3:       return 1'b1;
      5:       return (col == 1) || (col == 4);
      default: return (col == 0) || (col == 2) || (col == 3) || (col == 5);
    endcase
  endfunction

  task automatic recordPixel(string testName);
    int x;
    int y;
    x = int'(pixel.x);
    y = int'(pixel.y);
    if (x >= screenW || y >= screenH)
    begin
      otherErrors++;
      $display("%s: a pixel was drawn outside the screen at x %0d y %0d", testName, x, y);
    end
    else
    begin
      colorCount[pixel.color]++;
      colorWrites[pixel.color][x][y]++;
      screen[x][y] = pixel.color;
    end
  endtask

  // gathers one frame of pixels, returns one cycle after frameDone
  task automatic collectFrame(string testName);
    int c;
    int x;
    int y;
    int cycles;
    bit seenDone;
    for (c = 0; c < 8; c++)
    begin
      colorCount[c] = 0;
      for (x = 0; x < screenW; x++)
        for (y = 0; y < screenH; y++)
          colorWrites[c][x][y] = 0;
    end
    cycles   = 0;
    seenDone = 1'b0;
    while (!seenDone && cycles < frameLimit)
    begin
      @(negedge clk);
      cycles++;
      if (pixel.valid)
        recordPixel(testName);
      if (frameDone)
        seenDone = 1'b1;
    end
    if (!seenDone)
    begin
      otherErrors++;
      aborted = 1'b1;
      $display("%s: frameDone did not arrive within %0d cycles", testName, frameLimit);
    end
    else
    begin
      @(negedge clk);
      hitAfter = int'(hitCount);
    end
  endtask

  task automatic runFrame(string testName, int sx, int sy, int tx, bit first);
    int ex;
    int ey;
    int et;
    int ox;
    int oy;
    int x;
    int y;
    int fieldX1;
    int badBlack;
    int badEdge;
    int badCyan;
    int badYellow;
    int badRed;
    if (aborted)
      return;
    shipX   = cellT'(sx);                 // sampled at the start of the next frame
    shipY   = cellT'(sy);
    targetX = cellT'(tx);
    collectFrame(testName);
    if (aborted)
      return;
    ex      = clampTo(sx, gridCols - 1);
    ey      = clampTo(sy, gridRows - 1);
    et      = clampTo(tx, gridCols - 1);
    fieldX1 = fieldXOff + gridCols * cellSize - 1;
    badBlack = 0;
    badEdge  = 0;
    badCyan  = 0;
    for (x = 0; x < screenW; x++)
      for (y = 0; y < screenH; y++)
      begin
        if (x >= fieldXOff && x <= fieldX1)
        begin
          if (colorWrites[colorBlack][x][y] != 1)
            badBlack++;
        end
        else if (screen[x][y] != colorCyan)
          badEdge++;                      // border keeps the first cyan fill
        if (first && colorWrites[colorCyan][x][y] != 1)
          badCyan++;
      end
    checkValue(testName, "cyan pixels", first ? screenW * screenH : 0, colorCount[colorCyan]);
    checkValue(testName, "positions not cyan exactly once", 0, badCyan);
    checkValue(testName, "black pixels", gridCols * cellSize * screenH, colorCount[colorBlack]);
    checkValue(testName, "playfield positions not cleared once", 0, badBlack);
    checkValue(testName, "border positions not cyan", 0, badEdge);
    badYellow = 0;
    badRed    = 0;
    for (y = 0; y < cellSize; y++)
      for (x = 0; x < cellSize; x++)
      begin
        ox = et * cellSize + fieldXOff;
        oy = targetRow * cellSize;
        if (colorWrites[colorYellow][ox + x][oy + y] != 1)
          badYellow++;
        ox = ex * cellSize + fieldXOff;
        oy = ey * cellSize;
        if (shipPixelSet(y, x) && colorWrites[colorRed][ox + x][oy + y] != 1)
          badRed++;
      end
    checkValue(testName, "yellow pixels", 36, colorCount[colorYellow]);
    checkValue(testName, "target positions not yellow once", 0, badYellow);
    checkValue(testName, "red pixels", 22, colorCount[colorRed]);
    checkValue(testName, "ship positions not red once", 0, badRed);
    if (ex == et && ey == targetRow)
      expHits = (expHits + 1) % 256;
    checkValue(testName, "hitCount", expHits, hitAfter);
  endtask

  task automatic resetTest();
    repeat (8)
    begin
      @(negedge clk);
      checkValue("reset", "pixel valid", 0, int'(pixel.valid));
      checkValue("reset", "frameDone", 0, int'(frameDone));
      checkValue("reset", "hitCount", 0, int'(hitCount));
    end
    rstN = 1'b1;                          // released on a falling edge
    @(negedge clk);
    checkValue("after reset", "pixel valid", 0, int'(pixel.valid));
    checkValue("after reset", "frameDone", 0, int'(frameDone));
    checkValue("after reset", "hitCount", 0, int'(hitCount));
  endtask

  task automatic firstFrameTest();
    runFrame("first frame", 0, 0, 0, 1'b1);
  endtask

  task automatic targetTest();
    int tx;
    repeat (4)
    begin
      tx = $unsigned($random(seed)) % gridCols;
      runFrame("target square", 1, 7, tx, 1'b0);
    end
  endtask

  task automatic shipTest();
    int sx;
    int sy;
    int tx;
    repeat (4)
    begin
      sx = $unsigned($random(seed)) % gridCols;
      sy = $unsigned($random(seed)) % gridRows;
      tx = $unsigned($random(seed)) % gridCols;
      runFrame("ship sprite", sx, sy, tx, 1'b0);
    end
  endtask

  task automatic hitTest();
    runFrame("hit count", 0, 2, 0, 1'b0);
    runFrame("hit count", 3, 2, 3, 1'b0);
    runFrame("hit count", 5, 2, 5, 1'b0);
    runFrame("hit count", 1, 2, 4, 1'b0);  // column differs
    runFrame("hit count", 3, 5, 3, 1'b0);  // row differs
  endtask

  task automatic clampTest();
    runFrame("clamped inputs", 15, 15, 9, 1'b0);
    runFrame("clamped inputs", 9, 2, 12, 1'b0);
  endtask

  initial
  begin
    clk     = 1'b0;
    rstN    = 1'b0;
    shipX   = '0;
    shipY   = '0;
    targetX = '0;
    mismatchCount = 0;
    otherErrors   = 0;
    expHits       = 0;
    aborted       = 1'b0;
    resetTest();
    firstFrameTest();
    targetTest();
    shipTest();
    hitTest();
    clampTest();
    $display("mismatches %0d, other errors %0d", mismatchCount, otherErrors);
    if (mismatchCount == 0 && otherErrors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: testbench/gameFrame_sva.sv
`timescale 1ns/1ns

module gameFrameSva
  (
    input logic           clk,
    input logic           rstN,
    input gamePkg::pixelT pixel,
    input logic           frameDone
  );

  import gamePkg::*;

  pixelOnScreen: assert property (
    @(posedge clk) disable iff (!rstN)
    pixel.valid |-> (pixel.x < coordT'(screenW)) && (pixel.y < coordT'(screenH))
  )
  else $error("valid pixel outside the screen");

  frameDoneSingle: assert property (
    @(posedge clk) disable iff (!rstN)
    frameDone |=> !frameDone
  )
  else $error("frameDone longer than one cycle");

  // drawers are idle while the frame closes
  quietAtFrameDone: assert property (
    @(posedge clk) disable iff (!rstN)
    frameDone |-> !pixel.valid
  )
  else $error("pixel valid together with frameDone");

endmodule

// File: logic/gameFrameTop.sv
`timescale 1ns/1ns

module gameFrameTop
  (
    input  logic           clk,
    input  logic           rstN,
    input  gamePkg::cellT  shipX,
    input  gamePkg::cellT  shipY,
    input  gamePkg::cellT  targetX,
    output gamePkg::pixelT pixel,
    output logic [7:0]     hitCount,
    output logic           frameDone
  );

  import gamePkg::*;

  posT   pos;
  rectT  fillRect;
  pixelT fillPixel;
  pixelT stampPixel;
  coordT stampX;
  coordT stampY;
  colorT stampColor;
  logic  fillStart;
  logic  fillDone;
  logic  stampStart;
  logic  stampDone;
  logic  frameSample;
  logic  hit;

  gameRegs u_gameRegs (
    .clk         (clk),
    .rstN        (rstN),
    .frameSample (frameSample),
    .hit         (hit),
    .shipX       (shipX),
    .shipY       (shipY),
    .targetX     (targetX),
    .pos         (pos),
    .hitCount    (hitCount)
  );

  frameSequencer u_frameSequencer (
    .clk         (clk),
    .rstN        (rstN),
    .pos         (pos),
    .fillPixel   (fillPixel),
    .fillDone    (fillDone),
    .stampPixel  (stampPixel),
    .stampDone   (stampDone),
    .fillStart   (fillStart),
    .fillRect    (fillRect),
    .stampStart  (stampStart),
    .stampX      (stampX),
    .stampY      (stampY),
    .stampColor  (stampColor),
    .frameSample (frameSample),
    .hit         (hit),
    .pixel       (pixel),
    .frameDone   (frameDone)
  );

  rectFiller u_rectFiller (
    .clk       (clk),
    .rstN      (rstN),
    .fillStart (fillStart),
    .fillRect  (fillRect),
    .pixel     (fillPixel),
    .done      (fillDone)
  );

  shipStamper u_shipStamper (
    .clk        (clk),
    .rstN       (rstN),
    .stampStart (stampStart),
    .stampX     (stampX),
    .stampY     (stampY),
    .stampColor (stampColor),
    .pixel      (stampPixel),
    .done       (stampDone)
  );

endmodule

// File: logic/frameSequencer.sv
`timescale 1ns/1ns

module frameSequencer
  (
    input  logic           clk,
    input  logic           rstN,
    input  gamePkg::posT   pos,
    input  gamePkg::pixelT fillPixel,
    input  logic           fillDone,
    input  gamePkg::pixelT stampPixel,
    input  logic           stampDone,
    output logic           fillStart,
    output gamePkg::rectT  fillRect,
    output logic           stampStart,
    output gamePkg::coordT stampX,
    output gamePkg::coordT stampY,
    output gamePkg::colorT stampColor,
    output logic           frameSample,
    output logic           hit,
    output gamePkg::pixelT pixel,
    output logic           frameDone
  );

  import gamePkg::*;

  typedef enum logic [3:0] {
    stSample,
    stCyan,
    stCyanRun,
    stBlack,
    stBlackRun,
    stTarget,
    stTargetRun,
    stShip,
    stShipRun,
    stCheck,
    stWait,
    stDone
  } stateT;

  stateT state;
  stateT nextState;

  logic                          firstFrame;    // cyan fill still pending
  logic                          hitFlag;
  logic                          shipOnTarget;
  logic [$clog2(waitCycles)-1:0] waitCnt;
  logic                          waitOver;
  coordT                         targetPixX;

  // grid cell to pixel origin
  assign targetPixX = coordT'(pos.targetX * cellSize + fieldXOff);
  assign stampX     = coordT'(pos.shipX * cellSize + fieldXOff);
  assign stampY     = coordT'(pos.shipY * cellSize);
  assign stampColor = colorRed;

  assign shipOnTarget = (pos.shipX == pos.targetX) && (pos.shipY == cellT'(targetRow));
  assign waitOver     = (waitCnt == $bits(waitCnt)'(waitCycles - 1));

  assign frameSample = (state == stSample);
  assign fillStart   = (state == stCyan) || (state == stBlack) || (state == stTarget);
  assign stampStart  = (state == stShip);
  assign frameDone   = (state == stDone);
  assign hit         = frameDone && hitFlag;   // counted on the frameDone edge

  always_comb
  begin
    nextState = state;
    case (state)
      stSample:    nextState = firstFrame ? stCyan : stBlack;
      stCyan:      nextState = stCyanRun;
      stCyanRun:   if (fillDone) nextState = stBlack;
      stBlack:     nextState = stBlackRun;
      stBlackRun:  if (fillDone) nextState = stTarget;
      stTarget:    nextState = stTargetRun;
      stTargetRun: if (fillDone) nextState = stShip;
      stShip:      nextState = stShipRun;
      stShipRun:   if (stampDone) nextState = stCheck;
      stCheck:     nextState = stWait;
      stWait:      if (waitOver) nextState = stDone;
      stDone:      nextState = stSample;
      default:     nextState = stSample;
    endcase
  end

  // rectangle for the fill about to start
  always_comb
  begin
    fillRect.x0    = coordT'(fieldXOff);                          // playfield clear
    fillRect.y0    = '0;
    fillRect.x1    = coordT'(fieldXOff + gridCols * cellSize - 1);
    fillRect.y1    = coordT'(screenH - 1);
    fillRect.color = colorBlack;
    case (state)
      stCyan:
      begin
        fillRect.x0    = '0;
        fillRect.x1    = coordT'(screenW - 1);
        fillRect.color = colorCyan;
      end
      stTarget:
      begin
        fillRect.x0    = targetPixX;
        fillRect.y0    = coordT'(targetRow * cellSize);
        fillRect.x1    = targetPixX + coordT'(cellSize - 1);
        fillRect.y1    = coordT'(targetRow * cellSize + cellSize - 1);
        fillRect.color = colorYellow;
      end
      default:
        fillRect.color = colorBlack;
    endcase
  end

  // pass through whichever drawer is running
  always_comb
  begin
    case (state)
      stCyanRun, stBlackRun, stTargetRun: pixel = fillPixel;
      stShipRun:                          pixel = stampPixel;
      default:                            pixel = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state      <= stSample;
      firstFrame <= 1'b1;
      hitFlag    <= 1'b0;
      waitCnt    <= '0;
    end
    else
    begin
      state <= nextState;
      if ((state == stCyanRun) && fillDone)
        firstFrame <= 1'b0;
      if (state == stCheck)
      begin
        hitFlag <= shipOnTarget;
        waitCnt <= '0;
      end
      if (state == stWait)
        waitCnt <= waitCnt + 1'b1;
    end
  end

endmodule

// File: logic/gameRegs.sv
`timescale 1ns/1ns

module gameRegs
  (
    input  logic          clk,
    input  logic          rstN,
    input  logic          frameSample,
    input  logic          hit,
    input  gamePkg::cellT shipX,
    input  gamePkg::cellT shipY,
    input  gamePkg::cellT targetX,
    output gamePkg::posT  pos,
    output logic [7:0]    hitCount
  );

  import gamePkg::*;

  // limits a grid coordinate to the last valid cell
  function automatic cellT clampCell(cellT value, int unsigned cells);
    cellT maxCell;
    maxCell = cellT'(cells - 1);
    if (value > maxCell)
      return maxCell;
    else
      return value;
  endfunction

  posT nextPos;

  always_comb
  begin
    nextPos.shipX   = clampCell(shipX, gridCols);
    nextPos.shipY   = clampCell(shipY, gridRows);
    nextPos.targetX = clampCell(targetX, gridCols);
  end

  // one snapshot per frame
  always_ff @(posedge clk)
  begin
    if (frameSample)
      pos <= nextPos;
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      hitCount <= '0;
    else if (hit)
      hitCount <= hitCount + 1'b1;   // wraps at 256
  end

endmodule

// File: logic/shipStamper.sv
`timescale 1ns/1ns

module shipStamper
  (
    input  logic           clk,
    input  logic           rstN,
    input  logic           stampStart,
    input  gamePkg::coordT stampX,
    input  gamePkg::coordT stampY,
    input  gamePkg::colorT stampColor,
    output gamePkg::pixelT pixel,
    output logic           done
  );

  import gamePkg::*;

  coordT      originX;   // top left of the sprite cell
  coordT      originY;
  colorT      color;
  logic [5:0] scanIdx;   // position in shipMask
  logic [2:0] colOff;
  logic [2:0] rowOff;
  logic       active;

  assign done = active && (scanIdx == 6'(cellSize * cellSize - 1));

  always_comb
  begin
    pixel.valid = active && shipMask[scanIdx];  // only set bits are drawn
    pixel.x     = originX + coordT'(colOff);
    pixel.y     = originY + coordT'(rowOff);
    pixel.color = color;
  end

  always_ff @(posedge clk)
  begin
    if (stampStart)
    begin
      originX <= stampX;
      originY <= stampY;
      color   <= stampColor;
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      active  <= 1'b0;
      scanIdx <= '0;
      colOff  <= '0;
      rowOff  <= '0;
    end
    else if (stampStart)
    begin
      active  <= 1'b1;
      scanIdx <= '0;
      colOff  <= '0;
      rowOff  <= '0;
    end
    else if (active)
    begin
      if (done)
        active <= 1'b0;
      else
      begin
        scanIdx <= scanIdx + 1'b1;
        if (colOff == 3'(cellSize - 1))
        begin
          colOff <= '0;              // next sprite row
          rowOff <= rowOff + 1'b1;
        end
        else
          colOff <= colOff + 1'b1;
      end
    end
  end

endmodule

// File: logic/rectFiller.sv
`timescale 1ns/1ns

module rectFiller
  (
    input  logic           clk,
    input  logic           rstN,
    input  logic           fillStart,
    input  gamePkg::rectT  fillRect,
    output gamePkg::pixelT pixel,
    output logic           done
  );

  import gamePkg::*;

  rectT  rect;    // corners and color of the running fill
  coordT cntX;
  coordT cntY;
  logic  active;
  logic  lastX;   // at the right edge of the rectangle

  assign lastX = (cntX == rect.x1);
  assign done  = active && lastX && (cntY == rect.y1);

  always_comb
  begin
    pixel.valid = active;
    pixel.x     = cntX;
    pixel.y     = cntY;
    pixel.color = rect.color;
  end

  always_ff @(posedge clk)
  begin
    if (fillStart)
      rect <= fillRect;
  end

  // row-major scan, x inner
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      active <= 1'b0;
      cntX   <= '0;
      cntY   <= '0;
    end
    else if (fillStart)
    begin
      active <= 1'b1;
      cntX   <= fillRect.x0;
      cntY   <= fillRect.y0;
    end
    else if (active)
    begin
      if (done)
        active <= 1'b0;              // last pixel just went out
      else if (lastX)
      begin
        cntX <= rect.x0;             // wrap to left edge
        cntY <= cntY + 1'b1;
      end
      else
        cntX <= cntX + 1'b1;
    end
  end

endmodule

// File: logic/gamePkg.sv
package gamePkg;

  // screen geometry in pixels
  localparam int unsigned screenW    = 80;
  localparam int unsigned screenH    = 60;

  // playfield grid
  localparam int unsigned cellSize   = 6;   // pixels per grid cell
  localparam int unsigned fieldXOff  = 22;  // left edge of the playfield
  localparam int unsigned gridCols   = 6;
  localparam int unsigned gridRows   = 10;
  localparam int unsigned targetRow  = 2;   // target always sits in this row

  localparam int unsigned waitCycles = 16;  // idle gap between frames

  // 3-bit rgb color code
  typedef logic [2:0] colorT;

  localparam colorT colorBlack  = 3'b000;
  localparam colorT colorCyan   = 3'b011;
  localparam colorT colorYellow = 3'b110;
  localparam colorT colorRed    = 3'b100;

  typedef logic [6:0] coordT;  // pixel coordinate
  typedef logic [3:0] cellT;   // grid coordinate

  // ship bitmap, bit index is row * 6 + column
  localparam logic [35:0] shipMask = {
    6'b010010,  // row 5
    6'b101101,  // row 4
    6'b111111,  // row 3
    6'b101101,  // row 2
    6'b101101,  // row 1
    6'b001100   // row 0
  };

  typedef struct packed {
    logic  valid;
    coordT x;
    coordT y;
    colorT color;
  } pixelT;

  typedef struct packed {
    coordT x0;  // all corners inclusive
    coordT y0;
    coordT x1;
    coordT y1;
    colorT color;
  } rectT;

  typedef struct packed {
    cellT shipX;
    cellT shipY;
    cellT targetX;
  } posT;

endpackage
